// File: Bender.yml
package:
  name: fdd

sources:
  - fdd_pkg.sv
  - track_buf_if.sv
  - clock_enabler.sv
  - drive_config.sv
  - motor.sv
  - track.sv
  - transmit.sv
  - fdd.sv
  - target: test
    files:
      - fdd_tb.sv

// File: clock_enabler.sv
module clock_enabler #(
    parameter int CLK_HZ    = 50_000_000,
    parameter int TARGET_HZ = 1000
) (
    input  logic clk,
    input  logic rst,
    output logic en
);

    // at or above clk rate every cycle fires
    localparam int STEP  = (TARGET_HZ >= CLK_HZ) ? CLK_HZ : TARGET_HZ;
    localparam int ACC_W = $clog2(2 * CLK_HZ + 1);

    logic [ACC_W-1:0] acc;
    logic [ACC_W-1:0] acc_next;

    assign acc_next = acc + ACC_W'(STEP);

    always_ff @(posedge clk) begin
        if (rst) begin
            acc <= '0;
            en  <= 1'b0;
        end else if (acc_next >= ACC_W'(CLK_HZ)) begin
            acc <= acc_next - ACC_W'(CLK_HZ);
            en  <= 1'b1;
        end else begin
            acc <= acc_next;
            en  <= 1'b0;
        end
    end

    if (CLK_HZ >= 2 * TARGET_HZ) begin : g_en_check
        assert property (@(posedge clk) disable iff (rst) en |=> !en);
    end

endmodule

// File: drive_config.sv
module drive_config (
    input  logic               clk,
    input  logic               rst,
    input  logic               cfg_we,
    input  logic               cfg_unit,
    input  fdd_pkg::unit_cfg_t cfg_data,
    input  logic               usel,
    input  logic               img_mounted [2],
    input  logic               img_readonly [2],
    output fdd_pkg::unit_cfg_t sel_cfg,
    output logic               sel_mounted,
    output logic               sel_readonly,
    output logic               unit_changed
);
    import fdd_pkg::*;

    unit_cfg_t cfg_q [2];
    logic      mounted_q [2];
    logic      readonly_q [2];
    logic      usel_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            cfg_q      <= '{default: '0};
            mounted_q  <= '{default: 1'b0};
            readonly_q <= '{default: 1'b0};
            usel_q     <= 1'b0;
        end else begin
            if (cfg_we) begin
                cfg_q[cfg_unit] <= cfg_data;
            end
            mounted_q  <= img_mounted;   // image levels from the host side
            readonly_q <= img_readonly;
            usel_q     <= usel;
        end
    end

    // selection by usel, no extra cycle
    assign sel_cfg      = cfg_q[usel];
    assign sel_mounted  = mounted_q[usel];
    assign sel_readonly = readonly_q[usel];
    assign unit_changed = (usel != usel_q);  // one cycle after a switch

endmodule

// File: fdd.f
fdd_pkg.sv
track_buf_if.sv
clock_enabler.sv
drive_config.sv
motor.sv
track.sv
transmit.sv
fdd.sv
fdd_tb.sv

// File: fdd.sv
module fdd #(
    parameter int SYS_CLK_HZ = 50_000_000,
    parameter int TRACKS     = 80,
    parameter int DELAY_MS   = 3
) (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      cfg_we,
    input  logic                      cfg_unit,
    input  fdd_pkg::unit_cfg_t        cfg_data,
    input  logic                      img_mounted [2],
    input  logic                      img_readonly [2],
    input  logic                      usel,
    input  logic                      motor_n,
    input  logic                      step_n,
    input  logic                      sdir_n,
    input  logic                      side_n,
    input  logic                      bd_ack,
    input  logic [7:0]                bd_data,
    input  logic                      bd_data_valid,
    output logic                      ready_n,
    output logic                      wprot_n,
    output logic                      track0_n,
    output logic                      index_n,
    output logic                      read_data_n,
    output logic                      bd_rd,
    output logic [fdd_pkg::LBA_W-1:0] bd_lba,
    output logic                      bd_unit
);

    logic               ms_tick;
    logic               rpm300_en;
    logic               rpm360_en;
    logic               cell500_en;
    logic               cell1000_en;
    logic               motor_run;
    logic               sel_mounted;
    logic               sel_readonly;
    logic               unit_changed;
    fdd_pkg::unit_cfg_t sel_cfg;

    track_buf_if tbuf ();

    clock_enabler #(.CLK_HZ(SYS_CLK_HZ), .TARGET_HZ(1000)) fdd_ms (
        .clk(clk), .rst(rst), .en(ms_tick)
    );
    clock_enabler #(.CLK_HZ(SYS_CLK_HZ), .TARGET_HZ(5)) fdd_rpm300 (
        .clk(clk), .rst(rst), .en(rpm300_en)
    );
    clock_enabler #(.CLK_HZ(SYS_CLK_HZ), .TARGET_HZ(6)) fdd_rpm360 (
        .clk(clk), .rst(rst), .en(rpm360_en)
    );
    clock_enabler #(.CLK_HZ(SYS_CLK_HZ), .TARGET_HZ(500_000)) fdd_cell500 (  // 250 kbit
        .clk(clk), .rst(rst), .en(cell500_en)
    );
    clock_enabler #(.CLK_HZ(SYS_CLK_HZ), .TARGET_HZ(1_000_000)) fdd_cell1000 (
        .clk(clk), .rst(rst), .en(cell1000_en)
    );

    drive_config fdd_config (
        .clk(clk), .rst(rst), .cfg_we(cfg_we), .cfg_unit(cfg_unit), .cfg_data(cfg_data),
        .usel(usel), .img_mounted(img_mounted), .img_readonly(img_readonly),
        .sel_cfg(sel_cfg), .sel_mounted(sel_mounted), .sel_readonly(sel_readonly),
        .unit_changed(unit_changed)
    );

    motor #(.DELAY_MS(DELAY_MS)) fdd_motor (
        .clk(clk), .rst(rst), .ms_tick(ms_tick), .usel(usel), .motor_n(motor_n),
        .sel_mounted(sel_mounted), .sel_readonly(sel_readonly),
        .motor_run(motor_run), .ready_n(ready_n), .wprot_n(wprot_n)
    );

    track #(.TRACKS(TRACKS)) fdd_track (
        .clk(clk), .rst(rst), .ms_tick(ms_tick), .usel(usel), .step_n(step_n),
        .sdir_n(sdir_n), .side_n(side_n), .ready_n(ready_n), .unit_changed(unit_changed),
        .sel_cfg(sel_cfg), .bd_ack(bd_ack), .bd_data(bd_data), .bd_data_valid(bd_data_valid),
        .track0_n(track0_n), .bd_rd(bd_rd), .bd_lba(bd_lba), .bd_unit(bd_unit),
        .tb(tbuf.loader)
    );

    transmit fdd_transmit (
        .clk(clk), .rst(rst), .rpm300_en(rpm300_en), .rpm360_en(rpm360_en),
        .ms_tick(ms_tick), .cell500_en(cell500_en), .cell1000_en(cell1000_en),
        .motor_run(motor_run), .sel_cfg(sel_cfg),
        .index_n(index_n), .read_data_n(read_data_n), .tb(tbuf.reader)
    );

endmodule

// File: fdd_pkg.sv
package fdd_pkg;

    localparam int MAX_TRACK_BYTES = 8192;
    localparam int BUF_AW          = 13;
    localparam int TRACK_W         = 7;
    localparam int LBA_W           = 16;
    localparam int SECTOR_BYTES    = 128;  // one block, sector_size 0
    localparam int STEP_MS         = 3;    // head settle window
    localparam int INDEX_MS        = 2;

    typedef enum logic {ENC_FM, ENC_MFM} enc_e;
    typedef enum logic {DENS_250, DENS_500} dens_e;   // kbit/s
    typedef enum logic {RPM_300, RPM_360} speed_e;

    typedef struct packed {
        enc_e       mfm;
        logic       sides;        // 1 = double sided
        dens_e      density;
        speed_e     speed;
        logic [5:0] sectors;      // per track
        logic [1:0] sector_size;  // 128 << code
    } unit_cfg_t;

    // raw bytes in one track of one side
    function automatic logic [16:0] track_bytes(unit_cfg_t cfg);
        return 17'(cfg.sectors) << ($clog2(SECTOR_BYTES) + cfg.sector_size);
    endfunction

endpackage

// File: fdd_tb.sv
module fdd_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import fdd_pkg::*;

    localparam int TIMEOUT_CYCLES = 20000;  // about four times the whole test run
    localparam int STREAM_TRACK   = 11;
    localparam int CELL_LAT       = 2;      // ram read and byte load after index

    logic              clk;
    logic              rst;
    logic              cfg_we;
    logic              cfg_unit;
    unit_cfg_t         cfg_data;
    logic              img_mounted [2];
    logic              img_readonly [2];
    logic              usel;
    logic              motor_n;
    logic              step_n;
    logic              sdir_n;
    logic              side_n;
    logic              bd_ack;
    logic [7:0]        bd_data;
    logic              bd_data_valid;
    logic              ready_n;
    logic              wprot_n;
    logic              track0_n;
    logic              index_n;
    logic              read_data_n;
    logic              bd_rd;
    logic [LBA_W-1:0]  bd_lba;
    logic              bd_unit;

    unit_cfg_t         shadow [2];  // formats written so far
    logic [LBA_W-1:0]  req_lba;
    logic              req_unit;
    logic              rsp_busy;
    int                checks = 0;
    int                errors = 0;
    int                cycles;

    fdd #(.SYS_CLK_HZ(8000), .TRACKS(80), .DELAY_MS(3)) dut0 (.*);

    always #2 clk = ~clk;

    task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
                               input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0t: %s got %0h expected %0h", $time, what, got, exp);
        end
    endtask

    function automatic unit_cfg_t make_cfg(input logic mfm, input logic sides,
                                           input logic [5:0] sectors,
                                           input logic [1:0] size);
        unit_cfg_t c;
        c             = '0;
        c.mfm         = enc_e'(mfm);
        c.sides       = sides;
        c.density     = DENS_250;
        c.speed       = RPM_300;
        c.sectors     = sectors;
        c.sector_size = size;
        return c;
    endfunction

    function automatic int expected_lba(input int trk, input int side, input unit_cfg_t c);
        return (trk * (int'(c.sides) + 1) + side) * int'(c.sectors) * (1 << c.sector_size);
    endfunction

    // flux pulses for one byte, starting after a zero bit
    function automatic int expected_pulses(input logic [7:0] data, input logic mfm);
        int   n;
        logic prev;
        n    = 0;
        prev = 1'b0;
        for (int i = 7; i >= 0; i--) begin
            if (!mfm || (!prev && !data[i])) n++;  // clock cell
            if (data[i]) n++;
            prev = data[i];
        end
        return n;
    endfunction

    // answers every read, a new request cuts the running stream short
    task automatic serve_block_device();
        int          n_bytes;
        logic [15:0] lba;
        unit_cfg_t   c;
        bd_ack        = 1'b0;
        bd_data       = '0;
        bd_data_valid = 1'b0;
        rsp_busy <= 1'b0;
        req_lba  <= '0;
        req_unit <= 1'b0;
        forever begin
            @(negedge clk);
            if (!rst && bd_rd) begin
                c       = shadow[bd_unit];
                n_bytes = int'(c.sectors) * (128 << c.sector_size);
                lba     = bd_lba;
                req_lba  <= bd_lba;
                req_unit <= bd_unit;
                rsp_busy <= 1'b1;
                bd_ack = 1'b1;
                @(negedge clk);
                bd_ack = 1'b0;
                for (int i = 0; i < n_bytes; i++) begin
                    if (bd_rd) break;
                    bd_data       = lba[7:0] + 8'(i);
                    bd_data_valid = 1'b1;
                    @(negedge clk);
                end
                bd_data_valid = 1'b0;
                rsp_busy <= 1'b0;
            end
        end
    endtask

    task automatic write_cfg(input logic unit, input unit_cfg_t cfg);
        cfg_unit = unit;
        cfg_data = cfg;
        cfg_we   = 1'b1;
        if (unit) shadow[1] <= cfg;
        else shadow[0] <= cfg;
        @(negedge clk);
        cfg_we = 1'b0;
    endtask

    task automatic step_head(input logic inward);
        sdir_n = !inward;
        step_n = 1'b0;
        repeat (2) @(negedge clk);
        step_n = 1'b1;
        repeat (30) @(negedge clk);  // 4 ms apart
    endtask

    task automatic wait_load();
        @(negedge clk);
        while (!bd_rd) @(negedge clk);
        @(negedge clk);
        while (bd_rd || rsp_busy) @(negedge clk);
    endtask

    task automatic count_first_byte(output int pulses);
        pulses = 0;
        @(negedge clk);
        while (!index_n) @(negedge clk);
        while (index_n) @(negedge clk);
        repeat (CELL_LAT) @(negedge clk);
        repeat (16) begin
            @(negedge clk);
            if (!read_data_n) pulses++;
        end
    endtask

    task automatic reset_test();
        check_value(ready_n, 1'b1, "ready_n after reset");
        check_value(index_n, 1'b1, "index_n after reset");
        check_value(wprot_n, 1'b1, "wprot_n after reset");
        check_value(read_data_n, 1'b1, "read_data_n after reset");
        check_value(track0_n, 1'b0, "track0_n after reset");
        check_value(bd_rd, 1'b0, "bd_rd after reset");
    endtask

    task automatic spin_up_test();
        write_cfg(1'b0, make_cfg(1'b1, 1'b1, 6'd9, 2'd2));
        img_mounted[0]  = 1'b1;
        img_readonly[0] = 1'b1;
        @(negedge clk);
        motor_n = 1'b0;
        repeat (20) @(negedge clk);  // 2.5 ms
        check_value(ready_n, 1'b1, "ready_n during spin-up");
        repeat (14) @(negedge clk);
        check_value(ready_n, 1'b0, "ready_n after spin-up");
        check_value(wprot_n, 1'b0, "wprot_n on read-only image");
        motor_n = 1'b1;
        repeat (2) @(negedge clk);
        check_value(ready_n, 1'b1, "ready_n after motor off");
    endtask

    task automatic step_test();
        repeat (3) step_head(1'b1);
        check_value(track0_n, 1'b1, "track0_n after steps in");
        check_value(req_lba, expected_lba(3, 0, shadow[0]), "bd_lba at track 3");
        check_value(req_unit, 1'b0, "bd_unit at track 3");
        repeat (3) step_head(1'b0);
        check_value(track0_n, 1'b0, "track0_n after steps out");
    endtask

    task automatic stream_test(input logic mfm, input int trk);
        unit_cfg_t  c;
        int         pulses;
        int         exp_lba;
        logic [7:0] first;
        string      tag;
        c = make_cfg(mfm, 1'b0, 6'd1, 2'd0);
        if (mfm) tag = "mfm";
        else tag = "fm";
        motor_n = 1'b1;
        write_cfg(1'b0, c);
        @(negedge clk);
        motor_n = 1'b0;
        wait_load();
        exp_lba = expected_lba(trk, 0, c);
        check_value(req_lba, exp_lba, {tag, " load lba"});
        first = 8'(exp_lba);  // byte 0 of the image
        count_first_byte(pulses);
        check_value(pulses, expected_pulses(first, mfm), {tag, " pulses in first byte"});
    endtask

    task automatic unit_switch_test();
        usel = 1'b1;
        @(negedge clk);
        while (!bd_rd) @(negedge clk);
        check_value(bd_unit, 1'b1, "bd_unit after unit switch");
        check_value(bd_lba, expected_lba(0, 0, shadow[1]), "bd_lba after unit switch");
        check_value(track0_n, 1'b0, "track0_n on unit 1");
        repeat (34) @(negedge clk);  // unit 1 motor up to speed
        check_value(ready_n, 1'b1, "ready_n on unmounted unit");
    endtask

    initial serve_block_device();

    initial begin
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: tests still running after %0d cycles", TIMEOUT_CYCLES);
        $display("checks %0d, errors %0d", checks, errors);
        $display("Regression failed");
        $finish;
    end

    initial begin
        clk             = 1'b0;
        rst             = 1'b1;
        cfg_we          = 1'b0;
        cfg_unit        = 1'b0;
        cfg_data        = '0;
        img_mounted     = '{1'b0, 1'b0};
        img_readonly    = '{1'b0, 1'b0};
        usel            = 1'b0;
        motor_n         = 1'b1;
        step_n          = 1'b1;
        sdir_n          = 1'b1;
        side_n          = 1'b1;  // side 0
        shadow[0] <= '0;
        shadow[1] <= '0;
        repeat (8) @(negedge clk);
        rst = 1'b0;

        reset_test();
        spin_up_test();
        step_test();
        write_cfg(1'b0, make_cfg(1'b0, 1'b0, 6'd1, 2'd0));
        repeat (STREAM_TRACK) step_head(1'b1);
        stream_test(1'b0, STREAM_TRACK);
        stream_test(1'b1, STREAM_TRACK);
        unit_switch_test();

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// File: motor.sv
module motor #(
    parameter int DELAY_MS = 3
) (
    input  logic clk,
    input  logic rst,
    input  logic ms_tick,
    input  logic usel,
    input  logic motor_n,
    input  logic sel_mounted,
    input  logic sel_readonly,
    output logic motor_run,
    output logic ready_n,
    output logic wprot_n
);

    localparam int CNT_W = $clog2(DELAY_MS + 1);

    logic [CNT_W-1:0] spin_cnt [2];
    logic [1:0]       run;

    // motor line acts on the selected unit only
    always_ff @(posedge clk) begin
        if (rst) begin
            spin_cnt <= '{default: '0};
            run      <= '0;
        end else if (motor_n) begin
            spin_cnt[usel] <= '0;
            run[usel]      <= 1'b0;
        end else if (ms_tick && !run[usel]) begin
            if (spin_cnt[usel] == CNT_W'(DELAY_MS)) begin
                run[usel] <= 1'b1;  // up to speed
            end else begin
                spin_cnt[usel] <= spin_cnt[usel] + 1'b1;
            end
        end
    end

    assign motor_run = run[usel];
    assign ready_n   = !(motor_run && sel_mounted);
    assign wprot_n   = !sel_readonly;

    // ready only after a full spin-up
    assert property (@(posedge clk) disable iff (rst)
        !ready_n |-> (spin_cnt[usel] == CNT_W'(DELAY_MS)));

endmodule

// File: track.sv
module track #(
    parameter int TRACKS = 80
) (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      ms_tick,
    input  logic                      usel,
    input  logic                      step_n,
    input  logic                      sdir_n,
    input  logic                      side_n,
    input  logic                      ready_n,
    input  logic                      unit_changed,
    input  fdd_pkg::unit_cfg_t        sel_cfg,
    input  logic                      bd_ack,
    input  logic [7:0]                bd_data,
    input  logic                      bd_data_valid,
    output logic                      track0_n,
    output logic                      bd_rd,
    output logic [fdd_pkg::LBA_W-1:0] bd_lba,
    output logic                      bd_unit,
    track_buf_if.loader               tb
);
    import fdd_pkg::*;

    typedef enum logic [1:0] {IDLE, REQ, FILL, READY} state_e;

    localparam int BUSY_W = $clog2(STEP_MS + 1);

    state_e             state;
    logic [7:0]         mem [MAX_TRACK_BYTES];
    logic [TRACK_W-1:0] head [2];
    logic [TRACK_W-1:0] cur_track;
    logic [TRACK_W-1:0] track_q;
    logic [BUSY_W-1:0]  busy_cnt;
    logic               step_q;
    logic               step_go;
    logic               side;
    logic               side_q;
    logic               ready_q;
    logic               reload;
    logic [BUF_AW:0]    fill_cnt;
    logic [16:0]        track_len;
    logic [16:0]        lba_full;
    logic [7:0]         trk_idx;
    logic [8:0]         blk_per_trk;

    assign cur_track = head[usel];
    assign side      = !side_n;
    assign track0_n  = (cur_track != '0);
    assign step_go   = step_q && !step_n && (busy_cnt == '0);  // falling edge, not busy

    assign tb.track = cur_track;
    assign tb.side  = side;

    assign track_len   = track_bytes(sel_cfg);
    assign trk_idx     = (8'(cur_track) << sel_cfg.sides) + 8'(side);
    assign blk_per_trk = 9'(sel_cfg.sectors) << sel_cfg.sector_size;
    assign lba_full    = 17'(trk_idx) * 17'(blk_per_trk);

    assign reload = unit_changed || (cur_track != track_q) || (side != side_q) ||
                    (ready_q && !ready_n);

    always_ff @(posedge clk) begin
        if (rst) begin
            head     <= '{default: '0};
            step_q   <= 1'b1;
            busy_cnt <= '0;
        end else begin
            step_q <= step_n;
            if (step_go) begin
                busy_cnt <= BUSY_W'(STEP_MS);
                if (!sdir_n) begin
                    if (cur_track != TRACK_W'(TRACKS - 1)) head[usel] <= cur_track + 1'b1;
                end else if (cur_track != '0) begin
                    head[usel] <= cur_track - 1'b1;
                end
            end else if (ms_tick && busy_cnt != '0) begin
                busy_cnt <= busy_cnt - 1'b1;
            end
        end
    end

    // load fsm, any head or unit change restarts the read
    always_ff @(posedge clk) begin
        if (rst) begin
            state          <= IDLE;
            bd_rd          <= 1'b0;
            tb.track_ready <= 1'b0;
            fill_cnt       <= '0;
            track_q        <= '0;
            side_q         <= 1'b0;
            ready_q        <= 1'b1;
        end else begin
            track_q <= cur_track;
            side_q  <= side;
            ready_q <= ready_n;
            if (reload) begin
                state          <= REQ;
                bd_rd          <= 1'b1;
                tb.track_ready <= 1'b0;
                fill_cnt       <= '0;
                bd_lba         <= lba_full[LBA_W-1:0];
                bd_unit        <= usel;
            end else begin
                case (state)
                    REQ: if (bd_ack) begin
                        bd_rd          <= 1'b0;
                        state          <= (track_len == '0) ? READY : FILL;
                        tb.track_ready <= (track_len == '0);
                    end
                    FILL: if (bd_data_valid) begin
                        fill_cnt <= fill_cnt + 1'b1;
                        if (17'(fill_cnt) + 17'd1 == track_len) begin
                            state          <= READY;
                            tb.track_ready <= 1'b1;  // last byte stored
                        end
                    end
                    default: ;
                endcase
            end
        end
    end

    // track buffer ram
    always_ff @(posedge clk) begin
        if (state == FILL && bd_data_valid) begin
            mem[fill_cnt[BUF_AW-1:0]] <= bd_data;
        end
        tb.buf_q <= mem[tb.buf_addr];
    end

    assert property (@(posedge clk) disable iff (rst)
        (state == FILL && bd_data_valid) |-> (fill_cnt < MAX_TRACK_BYTES));

endmodule

// File: track_buf_if.sv
interface track_buf_if;
    import fdd_pkg::*;

    logic [BUF_AW-1:0]  buf_addr;
    logic [7:0]         buf_q;        // one cycle after buf_addr
    logic               track_ready;
    logic [TRACK_W-1:0] track;
    logic               side;

    modport loader (
        input  buf_addr,
        output buf_q,
        output track_ready,
        output track,
        output side
    );

    modport reader (
        output buf_addr,
        input  buf_q,
        input  track_ready,
        input  track,
        input  side
    );

endinterface

// File: transmit.sv
module transmit (
    input  logic               clk,
    input  logic               rst,
    input  logic               rpm300_en,
    input  logic               rpm360_en,
    input  logic               ms_tick,
    input  logic               cell500_en,
    input  logic               cell1000_en,
    input  logic               motor_run,
    input  fdd_pkg::unit_cfg_t sel_cfg,
    output logic               index_n,
    output logic               read_data_n,
    track_buf_if.reader        tb
);
    import fdd_pkg::*;

    localparam int IDX_W = $clog2(INDEX_MS + 1);

    logic               rev_en;
    logic               cell_en;
    logic               rev_start;
    logic [IDX_W-1:0]   idx_cnt;
    logic [16:0]        track_len;
    logic [BUF_AW-1:0]  next_addr;
    logic               active;
    logic               loaded;
    logic [1:0]         prime;      // ram read latency
    logic [7:0]         sh;
    logic [2:0]         bit_idx;
    logic               cell_ph;    // 0 clock cell, 1 data cell
    logic               prev_bit;
    logic               cell_one;
    logic [TRACK_W-1:0] cur_track;
    logic               cur_side;
    logic               stale;

    assign rev_en    = (sel_cfg.speed == RPM_360) ? rpm360_en : rpm300_en;
    assign cell_en   = (sel_cfg.density == DENS_500) ? cell1000_en : cell500_en;
    assign rev_start = rev_en && motor_run;  // one per revolution
    assign track_len = track_bytes(sel_cfg);
    assign next_addr = (17'(tb.buf_addr) + 17'd1 >= track_len) ? '0 : tb.buf_addr + 1'b1;
    assign stale     = active && ((tb.track != cur_track) || (tb.side != cur_side));

    always_ff @(posedge clk) begin
        if (rst) begin
            idx_cnt <= '0;
        end else if (rev_start) begin
            idx_cnt <= IDX_W'(INDEX_MS);
        end else if (ms_tick && idx_cnt != '0) begin
            idx_cnt <= idx_cnt - 1'b1;
        end
    end

    assign index_n = (idx_cnt == '0);

    // mfm clock bit only between two zeros
    always_comb begin
        if (!cell_ph) begin
            cell_one = (sel_cfg.mfm == ENC_MFM) ? (!prev_bit && !sh[7]) : 1'b1;
        end else begin
            cell_one = sh[7];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            active      <= 1'b0;
            loaded      <= 1'b0;
            prime       <= '0;
            tb.buf_addr <= '0;
            bit_idx     <= '0;
            cell_ph     <= 1'b0;
            prev_bit    <= 1'b0;
            read_data_n <= 1'b1;
        end else begin
            read_data_n <= 1'b1;
            if (!motor_run || !tb.track_ready || stale) begin
                active <= 1'b0;
                loaded <= 1'b0;
                prime  <= '0;
            end else if (rev_start) begin
                active      <= 1'b1;
                loaded      <= 1'b0;
                prime       <= 2'd2;
                tb.buf_addr <= '0;
                prev_bit    <= 1'b0;
                cur_track   <= tb.track;
                cur_side    <= tb.side;
            end else if (prime != '0) begin
                prime <= prime - 1'b1;
                if (prime == 2'd1) begin
                    sh          <= tb.buf_q;   // byte 0
                    loaded      <= 1'b1;
                    bit_idx     <= 3'd7;
                    cell_ph     <= 1'b0;
                    tb.buf_addr <= next_addr;
                end
            end else if (loaded && cell_en) begin
                read_data_n <= !cell_one;
                cell_ph     <= !cell_ph;
                if (cell_ph) begin
                    prev_bit <= sh[7];
                    sh       <= sh << 1;
                    bit_idx  <= bit_idx - 1'b1;
                    if (bit_idx == '0) begin
                        sh          <= tb.buf_q;
                        tb.buf_addr <= next_addr;  // wraps at track end
                    end
                end
            end
        end
    end

endmodule
